// File: logic/riscv_pkg.sv
`default_nettype none

package riscv_pkg;

   localparam int XLEN   = 32;              // data and address width
   localparam int REG_AW = 5;               // 32 architectural registers

   // major opcodes, rv32i base
   localparam logic [6:0] OPC_RTYPE  = 7'b0110011;
   localparam logic [6:0] OPC_ITYPE  = 7'b0010011;
   localparam logic [6:0] OPC_LOAD   = 7'b0000011;
   localparam logic [6:0] OPC_STORE  = 7'b0100011;
   localparam logic [6:0] OPC_BRANCH = 7'b1100011;

   // funct3 values of the supported subset
   localparam logic [2:0] F3_ADD = 3'b000;  // add, sub, addi
   localparam logic [2:0] F3_SLT = 3'b010;
   localparam logic [2:0] F3_OR  = 3'b110;
   localparam logic [2:0] F3_AND = 3'b111;
   localparam logic [2:0] F3_LW  = 3'b010;
   localparam logic [2:0] F3_SW  = 3'b010;
   localparam logic [2:0] F3_BEQ = 3'b000;

   // funct7, only bit 30 differs
   localparam logic [6:0] F7_BASE = 7'b0000000;
   localparam logic [6:0] F7_SUB  = 7'b0100000;

   typedef enum logic [2:0] {
      ALU_ADD = 3'd0,
      ALU_SUB = 3'd1,                       // also beq compare
      ALU_AND = 3'd2,
      ALU_OR  = 3'd3,
      ALU_SLT = 3'd4
   } alu_op_e;

   // result source, load is 2 so the hazard unit spots it
   localparam logic [1:0] RES_ALU = 2'd0;
   localparam logic [1:0] RES_MEM = 2'd2;

   // operand forward selects
   localparam logic [1:0] FWD_NONE = 2'd0;  // regfile value
   localparam logic [1:0] FWD_MEM  = 2'd1;  // alu result in memory stage
   localparam logic [1:0] FWD_WB   = 2'd2;  // writeback result

endpackage

`default_nettype wire

// File: logic/riscv_alu.sv
`timescale 1ns/1ps
`default_nettype none

module riscv_alu
   import riscv_pkg::*;
(
   input  logic [XLEN-1:0] i_op_a,
   input  logic [XLEN-1:0] i_op_b,
   input  alu_op_e         i_alu_op,
   output logic [XLEN-1:0] o_result,
   output logic            o_zero     // beq resolution
);

   logic lt_signed;

   assign lt_signed = $signed(i_op_a) < $signed(i_op_b);

   always_comb
   begin
      case (i_alu_op)
         ALU_ADD: o_result = i_op_a + i_op_b;
         ALU_SUB: o_result = i_op_a - i_op_b;
         ALU_AND: o_result = i_op_a & i_op_b;
         ALU_OR:  o_result = i_op_a | i_op_b;
         ALU_SLT: o_result = {{(XLEN-1){1'b0}}, lt_signed};
         default: o_result = '0;
      endcase
   end

   assign o_zero = (o_result == '0);

endmodule

`default_nettype wire

// File: logic/riscv_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module riscv_decoder
   import riscv_pkg::*;
(
   input  logic [XLEN-1:0]   i_instr,
   output logic [REG_AW-1:0] o_rs1_addr,
   output logic [REG_AW-1:0] o_rs2_addr,
   output logic [REG_AW-1:0] o_rd_addr,
   output logic [XLEN-1:0]   o_imm,
   output alu_op_e           o_alu_op,
   output logic              o_alu_src_imm,   // operand b from immediate
   output logic              o_regwrite,
   output logic              o_memwrite,
   output logic [1:0]        o_resultsrc,
   output logic              o_branch
);

   logic [6:0]      opcode;
   logic [2:0]      funct3;
   logic [6:0]      funct7;
   logic [XLEN-1:0] imm_i;
   logic [XLEN-1:0] imm_s;
   logic [XLEN-1:0] imm_b;

   assign opcode = i_instr[6:0];
   assign funct3 = i_instr[14:12];
   assign funct7 = i_instr[31:25];

   // register fields are fixed position in every format
   assign o_rs1_addr = i_instr[19:15];
   assign o_rs2_addr = i_instr[24:20];
   assign o_rd_addr  = i_instr[11:7];

   assign imm_i = {{(XLEN-12){i_instr[31]}}, i_instr[31:20]};
   assign imm_s = {{(XLEN-12){i_instr[31]}}, i_instr[31:25], i_instr[11:7]};
   assign imm_b = {{(XLEN-13){i_instr[31]}}, i_instr[31], i_instr[7],
                   i_instr[30:25], i_instr[11:8], 1'b0};   // halfword offset

   always_comb
   begin
      // defaults form a bubble
      o_imm         = '0;
      o_alu_op      = ALU_ADD;
      o_alu_src_imm = 1'b0;
      o_regwrite    = 1'b0;
      o_memwrite    = 1'b0;
      o_resultsrc   = RES_ALU;
      o_branch      = 1'b0;
      case (opcode)
         OPC_RTYPE:
         begin
            o_regwrite = 1'b1;
            case ({funct7, funct3})
               {F7_BASE, F3_ADD}: o_alu_op = ALU_ADD;
               {F7_SUB,  F3_ADD}: o_alu_op = ALU_SUB;
               {F7_BASE, F3_AND}: o_alu_op = ALU_AND;
               {F7_BASE, F3_OR}:  o_alu_op = ALU_OR;
               {F7_BASE, F3_SLT}: o_alu_op = ALU_SLT;
               default:           o_regwrite = 1'b0;   // unsupported funct
            endcase
         end
         OPC_ITYPE:
         begin
            if (funct3 == F3_ADD)   // addi only
            begin
               o_regwrite    = 1'b1;
               o_alu_src_imm = 1'b1;
               o_imm         = imm_i;
            end
         end
         OPC_LOAD:
         begin
            if (funct3 == F3_LW)
            begin
               o_regwrite    = 1'b1;
               o_alu_src_imm = 1'b1;   // base plus offset
               o_resultsrc   = RES_MEM;
               o_imm         = imm_i;
            end
         end
         OPC_STORE:
         begin
            if (funct3 == F3_SW)
            begin
               o_memwrite    = 1'b1;
               o_alu_src_imm = 1'b1;
               o_imm         = imm_s;
            end
         end
         OPC_BRANCH:
         begin
            if (funct3 == F3_BEQ)
            begin
               o_branch = 1'b1;
               o_alu_op = ALU_SUB;      // zero flag means equal
               o_imm    = imm_b;
            end
         end
         default:
         begin
            o_regwrite = 1'b0;          // unknown opcode stays a bubble
         end
      endcase
   end

endmodule

`default_nettype wire

// File: logic/riscv_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module riscv_regfile
   import riscv_pkg::*;
(
   input  logic              i_riscv_clk,
   input  logic              i_rst,
   input  logic [REG_AW-1:0] i_rs1_addr,
   input  logic [REG_AW-1:0] i_rs2_addr,
   input  logic [REG_AW-1:0] i_rd_addr,     // from writeback
   input  logic              i_rd_we,
   input  logic [XLEN-1:0]   i_rd_data,
   output logic [XLEN-1:0]   o_rs1_data,
   output logic [XLEN-1:0]   o_rs2_data
);

   logic [XLEN-1:0] rf_q [2**REG_AW];

   // x0 hardwired, same-cycle write passes straight through
   function automatic logic [XLEN-1:0] rd_port(input logic [REG_AW-1:0] addr);
      logic [XLEN-1:0] val;
      if (addr == '0)
         val = '0;
      else if (i_rd_we && (addr == i_rd_addr))
         val = i_rd_data;                   // writeback bypass
      else
         val = rf_q[addr];
      return val;
   endfunction

   always_ff @(posedge i_riscv_clk)
   begin
      if (i_rst)
      begin
         for (int i = 0; i < 2**REG_AW; i++)
         begin
            rf_q[i] <= '0;
         end
      end
      else if (i_rd_we && (i_rd_addr != '0))  // x0 never stored
      begin
         rf_q[i_rd_addr] <= i_rd_data;
      end
   end

   always_comb
   begin
      o_rs1_data = rd_port(i_rs1_addr);
      o_rs2_data = rd_port(i_rs2_addr);
   end

   assert property (@(posedge i_riscv_clk) disable iff (i_rst)
      (i_rd_we && (i_rd_addr == '0)) |=> (rf_q[0] == '0))
      else $error("x0 changed after a write to it");

endmodule

`default_nettype wire

// File: logic/riscv_hazardunit.sv
`timescale 1ns/1ps
`default_nettype none

module riscv_hazardunit
   import riscv_pkg::*;
(
   input  logic [REG_AW-1:0] i_riscv_hzrdu_rs1addr_d,   // decode sources
   input  logic [REG_AW-1:0] i_riscv_hzrdu_rs2addr_d,
   input  logic [REG_AW-1:0] i_riscv_hzrdu_rs1addr_e,   // execute sources
   input  logic [REG_AW-1:0] i_riscv_hzrdu_rs2addr_e,
   input  logic [REG_AW-1:0] i_riscv_hzrdu_rdaddr_e,
   input  logic [REG_AW-1:0] i_riscv_hzrdu_rdaddr_m,
   input  logic [REG_AW-1:0] i_riscv_hzrdu_rdaddr_w,
   input  logic              i_riscv_hzrdu_pcsrc,       // taken beq in execute
   input  logic              i_riscv_hzrdu_regw_m,
   input  logic              i_riscv_hzrdu_regw_w,
   input  logic [1:0]        i_riscv_hzrdu_resultsrc_e,
   output logic [1:0]        o_riscv_hzrdu_fwda,
   output logic [1:0]        o_riscv_hzrdu_fwdb,
   output logic              o_riscv_hzrdu_stallpc,
   output logic              o_riscv_hzrdu_stallfd,
   output logic              o_riscv_hzrdu_flushfd,
   output logic              o_riscv_hzrdu_flushde
);

   logic mem_live;   // memory stage writes a real register
   logic wb_live;    // same for writeback
   logic lw_stall;   // load in execute feeds decode

   // memory stage checked first since its value is newer
   function automatic logic [1:0] fwd_sel(input logic [REG_AW-1:0] rs);
      logic [1:0] sel;
      if (mem_live && (rs == i_riscv_hzrdu_rdaddr_m))
         sel = FWD_MEM;
      else if (wb_live && (rs == i_riscv_hzrdu_rdaddr_w))
         sel = FWD_WB;
      else
         sel = FWD_NONE;
      return sel;
   endfunction

   assign mem_live = i_riscv_hzrdu_regw_m && (i_riscv_hzrdu_rdaddr_m != '0);
   assign wb_live  = i_riscv_hzrdu_regw_w && (i_riscv_hzrdu_rdaddr_w != '0);

   // loaded data only exists after memory so hold one cycle
   assign lw_stall = (i_riscv_hzrdu_resultsrc_e == RES_MEM) &&
                     ((i_riscv_hzrdu_rs1addr_d == i_riscv_hzrdu_rdaddr_e) ||
                      (i_riscv_hzrdu_rs2addr_d == i_riscv_hzrdu_rdaddr_e));

   always_comb
   begin
      o_riscv_hzrdu_fwda    = fwd_sel(i_riscv_hzrdu_rs1addr_e);
      o_riscv_hzrdu_fwdb    = fwd_sel(i_riscv_hzrdu_rs2addr_e);
      o_riscv_hzrdu_stallpc = lw_stall;
      o_riscv_hzrdu_stallfd = lw_stall;
      o_riscv_hzrdu_flushfd = i_riscv_hzrdu_pcsrc;              // wrong-path fetch
      o_riscv_hzrdu_flushde = lw_stall || i_riscv_hzrdu_pcsrc;  // bubble or wrong-path decode
   end

   // execute holds one instruction, never both a load and a taken beq
   always_comb
   begin
      assert final (!(lw_stall && i_riscv_hzrdu_pcsrc))
         else $error("load-use stall and taken branch seen in the same cycle");
   end

endmodule

`default_nettype wire

// File: logic/riscv_core.sv
`timescale 1ns/1ps
`default_nettype none

module riscv_core
   import riscv_pkg::*;
(
   input  logic              i_riscv_clk,
   input  logic              i_rst,
   input  logic [XLEN-1:0]   i_imem_data,    // combinational from o_imem_addr
   input  logic [XLEN-1:0]   i_dmem_rdata,   // combinational from o_dmem_addr
   output logic [XLEN-1:0]   o_imem_addr,
   output logic [XLEN-1:0]   o_dmem_addr,
   output logic [XLEN-1:0]   o_dmem_wdata,
   output logic              o_dmem_we,
   output logic              o_wb_valid,
   output logic [REG_AW-1:0] o_wb_rd,
   output logic [XLEN-1:0]   o_wb_data
);

   // fetch
   logic [XLEN-1:0]   pc_f;
   // decode
   logic [XLEN-1:0]   instr_d;
   logic [XLEN-1:0]   pc_d;
   logic [REG_AW-1:0] rs1_addr_d;
   logic [REG_AW-1:0] rs2_addr_d;
   logic [REG_AW-1:0] rd_addr_d;
   logic [XLEN-1:0]   imm_d;
   alu_op_e           alu_ctl_d;
   logic              alu_src_imm_d;
   logic              regwrite_d;
   logic              memwrite_d;
   logic [1:0]        resultsrc_d;
   logic              branch_d;
   logic [XLEN-1:0]   rs1_data_d;
   logic [XLEN-1:0]   rs2_data_d;
   // execute
   logic              regwrite_e;
   logic              memwrite_e;
   logic [1:0]        resultsrc_e;
   logic              branch_e;
   alu_op_e           alu_ctl_e;
   logic              alu_src_imm_e;
   logic [XLEN-1:0]   rs1_data_e;
   logic [XLEN-1:0]   rs2_data_e;
   logic [XLEN-1:0]   imm_e;
   logic [XLEN-1:0]   pc_e;
   logic [REG_AW-1:0] rs1_addr_e;
   logic [REG_AW-1:0] rs2_addr_e;
   logic [REG_AW-1:0] rd_addr_e;
   logic [XLEN-1:0]   src_a_e;
   logic [XLEN-1:0]   fwd_b_e;
   logic [XLEN-1:0]   src_b_e;
   logic [XLEN-1:0]   alu_result_e;
   logic              zero_e;
   logic              pcsrc_e;
   logic [XLEN-1:0]   target_e;
   // memory
   logic              regwrite_m;
   logic              memwrite_m;
   logic [1:0]        resultsrc_m;
   logic [XLEN-1:0]   alu_result_m;
   logic [XLEN-1:0]   wdata_m;
   logic [REG_AW-1:0] rd_addr_m;
   // writeback
   logic              regwrite_w;
   logic [1:0]        resultsrc_w;
   logic [XLEN-1:0]   alu_result_w;
   logic [XLEN-1:0]   rdata_w;
   logic [REG_AW-1:0] rd_addr_w;
   logic [XLEN-1:0]   result_w;
   // hazard unit
   logic [1:0]        fwda;
   logic [1:0]        fwdb;
   logic              stallpc;
   logic              stallfd;
   logic              flushfd;
   logic              flushde;

   function automatic logic [XLEN-1:0] fwd_mux(input logic [1:0]      sel,
                                               input logic [XLEN-1:0] reg_val);
      logic [XLEN-1:0] val;
      case (sel)
         FWD_MEM: val = alu_result_m;
         FWD_WB:  val = result_w;
         default: val = reg_val;
      endcase
      return val;
   endfunction

   // taken branch wins over a load stall
   always_ff @(posedge i_riscv_clk)
   begin
      if (i_rst)
         pc_f <= '0;
      else if (pcsrc_e)
         pc_f <= target_e;
      else if (!stallpc)
         pc_f <= pc_f + XLEN'(4);
   end

   assign o_imem_addr = pc_f;

   always_ff @(posedge i_riscv_clk)
   begin
      if (i_rst || flushfd)
         instr_d <= '0;          // zero word decodes as bubble
      else if (!stallfd)
         instr_d <= i_imem_data;
   end

   always_ff @(posedge i_riscv_clk)
   begin
      if (!stallfd)
         pc_d <= pc_f;
   end

   riscv_decoder decoder_i (
      .i_instr       (instr_d),
      .o_rs1_addr    (rs1_addr_d),
      .o_rs2_addr    (rs2_addr_d),
      .o_rd_addr     (rd_addr_d),
      .o_imm         (imm_d),
      .o_alu_op      (alu_ctl_d),
      .o_alu_src_imm (alu_src_imm_d),
      .o_regwrite    (regwrite_d),
      .o_memwrite    (memwrite_d),
      .o_resultsrc   (resultsrc_d),
      .o_branch      (branch_d)
   );

   riscv_regfile regfile_i (
      .i_riscv_clk (i_riscv_clk),
      .i_rst       (i_rst),
      .i_rs1_addr  (rs1_addr_d),
      .i_rs2_addr  (rs2_addr_d),
      .i_rd_addr   (rd_addr_w),
      .i_rd_we     (regwrite_w),
      .i_rd_data   (result_w),
      .o_rs1_data  (rs1_data_d),
      .o_rs2_data  (rs2_data_d)
   );

   // execute control, cleared for load bubble or wrong path
   always_ff @(posedge i_riscv_clk)
   begin
      if (i_rst || flushde)
      begin
         regwrite_e  <= 1'b0;
         memwrite_e  <= 1'b0;
         resultsrc_e <= RES_ALU;
         branch_e    <= 1'b0;
      end
      else
      begin
         regwrite_e  <= regwrite_d;
         memwrite_e  <= memwrite_d;
         resultsrc_e <= resultsrc_d;
         branch_e    <= branch_d;
      end
   end

   always_ff @(posedge i_riscv_clk)
   begin
      alu_ctl_e     <= alu_ctl_d;
      alu_src_imm_e <= alu_src_imm_d;
      rs1_data_e    <= rs1_data_d;
      rs2_data_e    <= rs2_data_d;
      imm_e         <= imm_d;
      pc_e          <= pc_d;
      rs1_addr_e    <= rs1_addr_d;
      rs2_addr_e    <= rs2_addr_d;
      rd_addr_e     <= rd_addr_d;
   end

   always_comb
   begin
      src_a_e = fwd_mux(fwda, rs1_data_e);
      fwd_b_e = fwd_mux(fwdb, rs2_data_e);   // also store data
   end

   assign src_b_e = alu_src_imm_e ? imm_e : fwd_b_e;

   riscv_alu alu_i (
      .i_op_a   (src_a_e),
      .i_op_b   (src_b_e),
      .i_alu_op (alu_ctl_e),
      .o_result (alu_result_e),
      .o_zero   (zero_e)
   );

   assign pcsrc_e  = branch_e && zero_e;   // beq taken
   assign target_e = pc_e + imm_e;

   always_ff @(posedge i_riscv_clk)
   begin
      if (i_rst)
      begin
         regwrite_m  <= 1'b0;
         memwrite_m  <= 1'b0;
         resultsrc_m <= RES_ALU;
      end
      else
      begin
         regwrite_m  <= regwrite_e;
         memwrite_m  <= memwrite_e;
         resultsrc_m <= resultsrc_e;
      end
   end

   always_ff @(posedge i_riscv_clk)
   begin
      alu_result_m <= alu_result_e;
      wdata_m      <= fwd_b_e;
      rd_addr_m    <= rd_addr_e;
   end

   assign o_dmem_addr  = alu_result_m;
   assign o_dmem_wdata = wdata_m;
   assign o_dmem_we    = memwrite_m;     // one-cycle store strobe

   always_ff @(posedge i_riscv_clk)
   begin
      if (i_rst)
      begin
         regwrite_w  <= 1'b0;
         resultsrc_w <= RES_ALU;
      end
      else
      begin
         regwrite_w  <= regwrite_m;
         resultsrc_w <= resultsrc_m;
      end
   end

   always_ff @(posedge i_riscv_clk)
   begin
      alu_result_w <= alu_result_m;
      rdata_w      <= i_dmem_rdata;
      rd_addr_w    <= rd_addr_m;
   end

   assign result_w   = (resultsrc_w == RES_MEM) ? rdata_w : alu_result_w;
   assign o_wb_valid = regwrite_w && (rd_addr_w != '0);   // x0 writes not retired
   assign o_wb_rd    = rd_addr_w;
   assign o_wb_data  = result_w;

   riscv_hazardunit hazard_i (
      .i_riscv_hzrdu_rs1addr_d   (rs1_addr_d),
      .i_riscv_hzrdu_rs2addr_d   (rs2_addr_d),
      .i_riscv_hzrdu_rs1addr_e   (rs1_addr_e),
      .i_riscv_hzrdu_rs2addr_e   (rs2_addr_e),
      .i_riscv_hzrdu_rdaddr_e    (rd_addr_e),
      .i_riscv_hzrdu_rdaddr_m    (rd_addr_m),
      .i_riscv_hzrdu_rdaddr_w    (rd_addr_w),
      .i_riscv_hzrdu_pcsrc       (pcsrc_e),
      .i_riscv_hzrdu_regw_m      (regwrite_m),
      .i_riscv_hzrdu_regw_w      (regwrite_w),
      .i_riscv_hzrdu_resultsrc_e (resultsrc_e),
      .o_riscv_hzrdu_fwda        (fwda),
      .o_riscv_hzrdu_fwdb        (fwdb),
      .o_riscv_hzrdu_stallpc     (stallpc),
      .o_riscv_hzrdu_stallfd     (stallfd),
      .o_riscv_hzrdu_flushfd     (flushfd),
      .o_riscv_hzrdu_flushde     (flushde)
   );

   // the decode-stage instruction behind a taken beq must never execute
   assert property (@(posedge i_riscv_clk) disable iff (i_rst)
      pcsrc_e |=> !(regwrite_e || memwrite_e || branch_e))
      else $error("wrong-path instruction in execute after taken branch");

endmodule

`default_nettype wire

// File: dv/riscv_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module riscv_core_tb
   import riscv_pkg::*;
();

   logic              riscv_clk;
   logic              rst;
   logic [XLEN-1:0]   imem_data;
   logic [XLEN-1:0]   dmem_rdata;
   logic [XLEN-1:0]   imem_addr;
   logic [XLEN-1:0]   dmem_addr;
   logic [XLEN-1:0]   dmem_wdata;
   logic              dmem_we;
   logic              wb_valid;
   logic [REG_AW-1:0] wb_rd;
   logic [XLEN-1:0]   wb_data;

   logic [XLEN-1:0]   imem [256];        // word addressed, pc[9:2]
   logic [XLEN-1:0]   dmem [256];
   logic [XLEN-1:0]   exp_wb_rd [$];     // retirement order
   logic [XLEN-1:0]   exp_wb_data [$];
   logic [XLEN-1:0]   exp_st_addr [$];   // store order
   logic [XLEN-1:0]   exp_st_data [$];
   logic [XLEN-1:0]   loop_addr = '0;    // final self-loop beq
   int                w_idx = 0;
   int                s_idx = 0;
   int                mismatch_cnt = 0;
   int                other_cnt = 0;
   int                cycle_cnt = 0;
   int                cycle_limit = 0;
   int                n_words = 0;
   int                loop_visits = 0;
   bit                loaded = 1'b0;

   riscv_core dut_i (
      .i_riscv_clk  (riscv_clk),
      .i_rst        (rst),
      .i_imem_data  (imem_data),
      .i_dmem_rdata (dmem_rdata),
      .o_imem_addr  (imem_addr),
      .o_dmem_addr  (dmem_addr),
      .o_dmem_wdata (dmem_wdata),
      .o_dmem_we    (dmem_we),
      .o_wb_valid   (wb_valid),
      .o_wb_rd      (wb_rd),
      .o_wb_data    (wb_data)
   );

   // both memories answer in the same cycle
   assign imem_data  = imem[imem_addr[9:2]];
   assign dmem_rdata = dmem[dmem_addr[9:2]];

   initial
   begin
      riscv_clk = 1'b0;
      forever #5 riscv_clk = ~riscv_clk;
   end

   always @(posedge riscv_clk)
   begin
      cycle_cnt <= cycle_cnt + 1;
      if (dmem_we)
         dmem[dmem_addr[9:2]] <= dmem_wdata;   // store strobe
   end

   task automatic check_value(input string name, input logic [XLEN-1:0] got,
                              input logic [XLEN-1:0] exp);
      if (got !== exp)
      begin
         $display("MISMATCH %s: got %h, expected %h", name, got, exp);
         mismatch_cnt++;
      end
   endtask

   // tagged lines, last I line is the self-loop
   task automatic load_trace();
      int              fd;
      int              n;
      string           line;
      logic [7:0]      tag;
      logic [XLEN-1:0] a;
      logic [XLEN-1:0] v;
      for (int i = 0; i < 256; i++)
      begin
         imem[i] = '0;                                // zero word is a bubble
         dmem[i] <= 32'hDA7A_0000 | XLEN'(i << 2);    // nba, same as store port
      end
      fd = $fopen("dv/riscv_trace.txt", "r");
      if (fd == 0)
      begin
         $display("cannot open trace file dv/riscv_trace.txt");
         other_cnt++;
         return;
      end
      while (!$feof(fd))
      begin
         n = $fgets(line, fd);
         if (n == 0 || line.getc(0) == "#")
            continue;
         n = $sscanf(line, "%c %h %h", tag, a, v);
         if (n != 3)
            continue;                                 // blank line
         case (tag)
            "I":
            begin
               imem[a[9:2]] = v;
               loop_addr    = a;
               n_words++;
            end
            "D": dmem[a[9:2]] <= v;
            "W":
            begin
               exp_wb_rd.push_back(a);
               exp_wb_data.push_back(v);
            end
            "S":
            begin
               exp_st_addr.push_back(a);
               exp_st_data.push_back(v);
            end
            default:
            begin
               $display("unknown tag in trace line: %s", line);
               other_cnt++;
            end
         endcase
      end
      $fclose(fd);
      cycle_limit = 20 * n_words + 100;
      loaded      = 1'b1;
   endtask

   task automatic end_run();
      if (w_idx < exp_wb_rd.size())
      begin
         $display("%0d expected register writes never retired", exp_wb_rd.size() - w_idx);
         other_cnt++;
      end
      if (s_idx < exp_st_addr.size())
      begin
         $display("%0d expected stores never reached the data port",
                  exp_st_addr.size() - s_idx);
         other_cnt++;
      end
      $display("errors: %0d mismatches, %0d other failures", mismatch_cnt, other_cnt);
      if (mismatch_cnt == 0 && other_cnt == 0)
         $display("Test completed successfully");
      else
         $display("Test failed");
      $finish;
   endtask

   // outputs are stable mid cycle
   always @(negedge riscv_clk)
   begin
      if (!rst && wb_valid)
      begin
         if (w_idx < exp_wb_rd.size())
         begin
            check_value("o_wb_rd", XLEN'(wb_rd), exp_wb_rd[w_idx]);
            check_value("o_wb_data", wb_data, exp_wb_data[w_idx]);
            w_idx++;
         end
         else
         begin
            $display("register write x%0d = %h retired after all expected writes", wb_rd, wb_data);
            other_cnt++;
         end
      end
      if (!rst && dmem_we)
      begin
         if (s_idx < exp_st_addr.size())
         begin
            check_value("o_dmem_addr", dmem_addr, exp_st_addr[s_idx]);
            check_value("o_dmem_wdata", dmem_wdata, exp_st_data[s_idx]);
            s_idx++;
         end
         else
         begin
            $display("store to %h = %h after all expected stores", dmem_addr, dmem_wdata);
            other_cnt++;
         end
      end
   end

   initial
   begin
      rst = 1'b1;
      load_trace();
      if (loaded)
      begin
         repeat (10) @(posedge riscv_clk);
         rst <= 1'b0;
         // third fetch of the self-loop, older work has drained by then
         while (loop_visits < 3)
         begin
            @(negedge riscv_clk);
            if (imem_addr == loop_addr)
               loop_visits++;
         end
      end
      end_run();
   end

   initial
   begin
      wait (loaded && cycle_cnt >= cycle_limit);
      $display("timeout after %0d cycles, program never reached its self-loop", cycle_cnt);
      other_cnt++;
      end_run();
   end

endmodule

`default_nettype wire

// File: dv/riscv_trace.txt
# I: byte address, instruction word | D: byte address, initial data word
# W: register index, written value | S: store address, store data (all hex)
I 00000000 00500093  # addi x1, x0, 5
I 00000004 00c00113  # addi x2, x0, 12
I 00000008 ffd00193  # addi x3, x0, -3
I 0000000c 00208233  # add  x4, x1, x2    x2 from writeback
I 00000010 401202b3  # sub  x5, x4, x1    x4 from memory
I 00000014 004282b3  # add  x5, x5, x4
I 00000018 00128333  # add  x6, x5, x1    x5 in both stages, memory wins
I 0000001c 0011a3b3  # slt  x7, x3, x1
I 00000020 0042f433  # and  x8, x5, x4
I 00000024 002464b3  # or   x9, x8, x2
I 00000028 00708013  # addi x0, x1, 7     no retirement
I 0000002c 00100533  # add  x10, x0, x1   x0 reads zero
I 00000030 04002583  # lw   x11, 0x40(x0)
I 00000034 00158633  # add  x12, x11, x1  load-use stall
I 00000038 04c02223  # sw   x12, 0x44(x0) data forwarded
I 0000003c 04402683  # lw   x13, 0x44(x0)
I 00000040 00a08663  # beq  x1, x10, +12  taken
I 00000044 00100713  # addi x14, x0, 1    wrong path
I 00000048 00200793  # addi x15, x0, 2    wrong path
I 0000004c 00208463  # beq  x1, x2, +8    not taken
I 00000050 00168813  # addi x16, x13, 1
I 00000054 05002423  # sw   x16, 0x48(x0)
I 00000058 00000063  # beq  x0, x0, 0     self-loop
D 00000040 12345678
D 00000044 deadbeef
W 00000001 00000005
W 00000002 0000000c
W 00000003 fffffffd
W 00000004 00000011
W 00000005 0000000c
W 00000005 0000001d
W 00000006 00000022
W 00000007 00000001
W 00000008 00000011
W 00000009 0000001d
W 0000000a 00000005
W 0000000b 12345678
W 0000000c 1234567d
W 0000000d 1234567d
W 00000010 1234567e
S 00000044 1234567d
S 00000048 1234567e

// File: flist.f
logic/riscv_pkg.sv
logic/riscv_alu.sv
logic/riscv_decoder.sv
logic/riscv_regfile.sv
logic/riscv_hazardunit.sv
logic/riscv_core.sv
dv/riscv_core_tb.sv

// File: run.sh
#!/bin/sh
verilator --binary --timing --assert -f flist.f --top-module riscv_core_tb -o riscv_core_sim > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/riscv_core_sim > sim.log 2>&1 ; cat sim.log
grep -q "Test completed successfully" sim.log && exit 0 || exit 1
